//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // ------------------------------
    // Peripheral bus geometry
    // ------------------------------
    localparam int BUS_DAT_WIDTH = 32;
    localparam int BUS_SEL_WIDTH = 4;
    localparam int BUS_ADR_WIDTH = 24;

    typedef logic [BUS_DAT_WIDTH-1:0] bus_data_t;
    typedef logic [BUS_ADR_WIDTH-1:0] bus_adr_t;
    typedef logic [BUS_SEL_WIDTH-1:0] bus_sel_t;

    // Region field of the word address
    localparam int REGION_MSB = 23;
    localparam int REGION_LSB = 16;

    typedef enum logic [7:0] {
        REGION_MOTOR = 8'h02,
        REGION_TIMER = 8'h04,
        REGION_SYS   = 8'h08
    } region_e;

    // ------------------------------
    // System registers
    // ------------------------------
    typedef enum logic [0:0] {
        SYS_LED   = 1'b0,
        SYS_FLAGS = 1'b1
    } sys_reg_e;

    localparam int FLAG_MOTOR = 0;
    localparam int FLAG_TIMER = 1;

    // Merge write data into a register, one byte lane per byte enable
    function automatic bus_data_t write_bytes(bus_data_t cur, bus_data_t wdat, bus_sel_t sel);
        bus_data_t res;
        res = cur;
        for (int i = 0; i < BUS_SEL_WIDTH; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = wdat[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- src/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // ------------------------------
    // Stepper motor
    // ------------------------------
    localparam int POSITION_WIDTH = 32;
    localparam int STEP_WIDTH     = 16;

    typedef logic [POSITION_WIDTH-1:0] position_t;
    typedef logic [STEP_WIDTH-1:0]     step_t;
    typedef logic [1:0]                phase_t;
    typedef logic [3:0]                coil_t;

    typedef enum logic [2:0] {
        MOTOR_CTL      = 3'd0,
        MOTOR_TARGET   = 3'd1,
        MOTOR_STEP     = 3'd2,
        MOTOR_POSITION = 3'd3,
        MOTOR_PHASE    = 3'd4
    } motor_reg_e;

    typedef enum logic [1:0] {
        DIR_HOLD,
        DIR_UP,
        DIR_DOWN
    } motor_dir_e;

    // ------------------------------
    // Interval timer
    // ------------------------------
    localparam int TIMER_WIDTH = 32;

    typedef enum logic [1:0] {
        TIMER_CTL     = 2'd0,
        TIMER_COMPARE = 2'd1,
        TIMER_COUNT   = 2'd2
    } timer_reg_e;

endpackage

`default_nettype wire

//--- src/bus_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module bus_decoder import bus_pkg::*; (
    input  bus_adr_t  adr_i,
    input  wire       stb_i,
    input  bus_data_t motor_dat_i,
    input  bus_data_t timer_dat_i,
    input  bus_data_t sys_dat_i,
    output logic      motor_stb_o,
    output logic      timer_stb_o,
    output logic      sys_stb_o,
    output bus_data_t dat_o,
    output logic      ack_o
);

    logic [REGION_MSB:REGION_LSB] region;

    assign region = adr_i[REGION_MSB:REGION_LSB];

    assign motor_stb_o = stb_i && (region == REGION_MOTOR);
    assign timer_stb_o = stb_i && (region == REGION_TIMER);
    assign sys_stb_o   = stb_i && (region == REGION_SYS);

    // Unmapped regions read as zero
    always_comb begin
        if (motor_stb_o) begin
            dat_o = motor_dat_i;
        end else if (timer_stb_o) begin
            dat_o = timer_dat_i;
        end else if (sys_stb_o) begin
            dat_o = sys_dat_i;
        end else begin
            dat_o = '0;
        end
    end

    // All slaves are zero-wait
    assign ack_o = stb_i;

    always_comb begin
        assert ($onehot0({motor_stb_o, timer_stb_o, sys_stb_o}))
            else $error("bus_decoder: more than one slave strobe");
    end

endmodule

`default_nettype wire

//--- src/stepper_motor_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module stepper_motor_ctrl import bus_pkg::*, periph_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        stb_i,
    input  wire        we_i,
    input  motor_reg_e adr_i,
    input  bus_data_t  dat_i,
    input  bus_sel_t   sel_i,
    output bus_data_t  dat_o,
    output logic       event_o,
    output coil_t      coil_o
);

    logic       ctl_enable;
    logic       ctl_event_en;
    position_t  target;
    step_t      step_period;
    position_t  position;
    phase_t     phase;
    step_t      step_cnt;
    logic       event_q;
    motor_dir_e dir;
    logic       step;
    position_t  next_position;

    // Signed compare since position may run below zero
    always_comb begin
        if (!ctl_enable || position == target) begin
            dir = DIR_HOLD;
        end else if ($signed(target) > $signed(position)) begin
            dir = DIR_UP;
        end else begin
            dir = DIR_DOWN;
        end
    end

    assign step          = (dir != DIR_HOLD) && (step_cnt == step_period);
    assign next_position = (dir == DIR_UP) ? position + position_t'(1)
                                           : position - position_t'(1);

    // ------------------------------
    // Stepping and register writes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_enable   <= 1'b0;
            ctl_event_en <= 1'b0;
            target       <= '0;
            step_period  <= '0;
            position     <= '0;
            phase        <= '0;
            step_cnt     <= '0;
            event_q      <= 1'b0;
        end else begin
            event_q <= 1'b0;
            if (dir == DIR_HOLD) begin
                step_cnt <= '0;
            end else if (step) begin
                step_cnt <= '0;
                position <= next_position;
                phase    <= (dir == DIR_UP) ? phase + phase_t'(1) : phase - phase_t'(1);
                event_q  <= ctl_event_en && (next_position == target);
            end else begin
                step_cnt <= step_cnt + step_t'(1);
            end

            // Bus write overrides a step on the same edge
            if (stb_i && we_i) begin
                case (adr_i)
                    MOTOR_CTL: begin
                        if (sel_i[0]) begin
                            ctl_enable   <= dat_i[0];
                            ctl_event_en <= dat_i[1];
                        end
                    end
                    MOTOR_TARGET:   target      <= write_bytes(target, dat_i, sel_i);
                    MOTOR_STEP:     step_period <= step_t'(write_bytes(bus_data_t'(step_period),
                                                                       dat_i, sel_i));
                    MOTOR_POSITION: position    <= write_bytes(position, dat_i, sel_i);
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (adr_i)
            MOTOR_CTL:      dat_o = {30'd0, ctl_event_en, ctl_enable};
            MOTOR_TARGET:   dat_o = target;
            MOTOR_STEP:     dat_o = bus_data_t'(step_period);
            MOTOR_POSITION: dat_o = position;
            MOTOR_PHASE:    dat_o = bus_data_t'(phase);
            default:        dat_o = '0;
        endcase
    end

    assign event_o = event_q;

    // Coils off while disabled
    assign coil_o = ctl_enable ? {~phase[1], phase[1], ~phase[0], phase[0]} : '0;

    assert property (@(posedge clk) disable iff (reset)
        $changed(phase) |-> $past(step) && (phase_t'(phase - $past(phase)) inside {2'd1, 2'd3}))
        else $error("stepper_motor_ctrl: phase moved without a single step");

endmodule

`default_nettype wire

//--- src/interval_timer.sv
`timescale 1ns/1ns
`default_nettype none

module interval_timer import bus_pkg::*, periph_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        stb_i,
    input  wire        we_i,
    input  timer_reg_e adr_i,
    input  bus_data_t  dat_i,
    input  bus_sel_t   sel_i,
    output bus_data_t  dat_o,
    output logic       event_o
);

    logic                   enable;
    logic [TIMER_WIDTH-1:0] compare;
    logic [TIMER_WIDTH-1:0] count;
    logic                   event_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable  <= 1'b0;
            compare <= '0;
            count   <= '0;
            event_q <= 1'b0;
        end else begin
            event_q <= 1'b0;
            if (!enable) begin
                count <= '0;
            end else if (count >= compare) begin
                // Period is compare + 1 cycles
                count   <= '0;
                event_q <= 1'b1;
            end else begin
                count <= count + TIMER_WIDTH'(1);
            end

            if (stb_i && we_i) begin
                case (adr_i)
                    TIMER_CTL: begin
                        if (sel_i[0]) begin
                            enable <= dat_i[0];
                        end
                    end
                    TIMER_COMPARE: compare <= write_bytes(compare, dat_i, sel_i);
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (adr_i)
            TIMER_CTL:     dat_o = {31'd0, enable};
            TIMER_COMPARE: dat_o = compare;
            TIMER_COUNT:   dat_o = count;
            default:       dat_o = '0;
        endcase
    end

    assign event_o = event_q;

    // A compare of zero fires every cycle by design
    assert property (@(posedge clk) disable iff (reset)
        event_o |=> !event_o || compare == '0)
        else $error("interval_timer: event held for two cycles");

endmodule

`default_nettype wire

//--- src/sys_regs.sv
`timescale 1ns/1ns
`default_nettype none

module sys_regs import bus_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       stb_i,
    input  wire       we_i,
    input  sys_reg_e  adr_i,
    input  bus_data_t dat_i,
    input  bus_sel_t  sel_i,
    input  wire       motor_event_i,
    input  wire       timer_event_i,
    output bus_data_t dat_o,
    output logic      led_o,
    output logic      irq_o
);

    logic                       led_q;
    logic [FLAG_TIMER:FLAG_MOTOR] flags;
    logic [FLAG_TIMER:FLAG_MOTOR] flag_set;
    logic [FLAG_TIMER:FLAG_MOTOR] flag_clr;
    logic                       irq_q;
    logic                       wr;

    assign wr = stb_i && we_i && sel_i[0];

    always_comb begin
        flag_set             = '0;
        flag_set[FLAG_MOTOR] = motor_event_i;
        flag_set[FLAG_TIMER] = timer_event_i;
    end

    // Write one to clear
    assign flag_clr = (wr && adr_i == SYS_FLAGS) ? dat_i[FLAG_TIMER:FLAG_MOTOR] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            led_q <= 1'b0;
            flags <= '0;
            irq_q <= 1'b0;
        end else begin
            if (wr && adr_i == SYS_LED) begin
                led_q <= dat_i[0];
            end
            // Set wins over a coinciding clear
            flags <= (flags & ~flag_clr) | flag_set;
            irq_q <= |flags;
        end
    end

    assign dat_o = (adr_i == SYS_FLAGS) ? bus_data_t'(flags) : bus_data_t'(led_q);
    assign led_o = led_q;
    assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- src/motor_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module motor_periph_top import bus_pkg::*, periph_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  bus_adr_t  wb_adr_i,
    input  bus_data_t wb_dat_i,
    input  wire       wb_we_i,
    input  bus_sel_t  wb_sel_i,
    input  wire       wb_stb_i,
    output bus_data_t wb_dat_o,
    output logic      wb_ack_o,
    output coil_t     coil_o,
    output logic      led_o,
    output logic      irq_o
);

    logic      motor_stb;
    logic      timer_stb;
    logic      sys_stb;
    bus_data_t motor_dat;
    bus_data_t timer_dat;
    bus_data_t sys_dat;
    logic      motor_event;
    logic      timer_event;

    // ------------------------------
    // Region decode
    // ------------------------------
    bus_decoder bus_decoder_i (
        .adr_i       (wb_adr_i),
        .stb_i       (wb_stb_i),
        .motor_dat_i (motor_dat),
        .timer_dat_i (timer_dat),
        .sys_dat_i   (sys_dat),
        .motor_stb_o (motor_stb),
        .timer_stb_o (timer_stb),
        .sys_stb_o   (sys_stb),
        .dat_o       (wb_dat_o),
        .ack_o       (wb_ack_o)
    );

    // ------------------------------
    // Peripherals
    // ------------------------------
    stepper_motor_ctrl stepper_motor_ctrl_i (
        .clk     (clk),
        .reset   (reset),
        .stb_i   (motor_stb),
        .we_i    (wb_we_i),
        .adr_i   (motor_reg_e'(wb_adr_i[$bits(motor_reg_e)-1:0])),
        .dat_i   (wb_dat_i),
        .sel_i   (wb_sel_i),
        .dat_o   (motor_dat),
        .event_o (motor_event),
        .coil_o  (coil_o)
    );

    interval_timer interval_timer_i (
        .clk     (clk),
        .reset   (reset),
        .stb_i   (timer_stb),
        .we_i    (wb_we_i),
        .adr_i   (timer_reg_e'(wb_adr_i[$bits(timer_reg_e)-1:0])),
        .dat_i   (wb_dat_i),
        .sel_i   (wb_sel_i),
        .dat_o   (timer_dat),
        .event_o (timer_event)
    );

    sys_regs sys_regs_i (
        .clk           (clk),
        .reset         (reset),
        .stb_i         (sys_stb),
        .we_i          (wb_we_i),
        .adr_i         (sys_reg_e'(wb_adr_i[$bits(sys_reg_e)-1:0])),
        .dat_i         (wb_dat_i),
        .sel_i         (wb_sel_i),
        .motor_event_i (motor_event),
        .timer_event_i (timer_event),
        .dat_o         (sys_dat),
        .led_o         (led_o),
        .irq_o         (irq_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_motor_periph.sv
`timescale 1ns/1ns
`default_nettype none

module tb_motor_periph import bus_pkg::*, periph_pkg::*; ();

    localparam int CLK_HALF       = 4;
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk;
    logic      reset;
    bus_adr_t  wb_adr;
    bus_data_t wb_dat;
    logic      wb_we;
    bus_sel_t  wb_sel;
    logic      wb_stb;
    bus_data_t wb_rdat;
    logic      wb_ack;
    coil_t     coil;
    logic      led;
    logic      irq;

    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] rng;

    motor_periph_top motor_periph_top_i (
        .clk      (clk),
        .reset    (reset),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack),
        .coil_o   (coil),
        .led_o    (led),
        .irq_o    (irq)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bus_adr_t reg_adr(input region_e region, input logic [15:0] offset);
        return {region, offset};
    endfunction

    // Coils are the phase bits and their inverses
    function automatic coil_t coil_pattern(input phase_t p);
        coil_t c;
        c[0] = p[0];
        c[1] = !p[0];
        c[2] = p[1];
        c[3] = !p[1];
        return c;
    endfunction

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_coil(input string name, input coil_t exp, input coil_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s: expected 4'b%04b, actual 4'b%04b", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One zero-wait access; ack and read data are sampled mid-cycle
    task automatic bus_access(input bus_adr_t adr, input logic we, input bus_data_t wdat,
                              input bus_sel_t sel, output bus_data_t rdat);
        @(negedge clk);
        wb_adr = adr;
        wb_we  = we;
        wb_dat = wdat;
        wb_sel = sel;
        wb_stb = 1'b1;
        #1;
        check_bit("bus ack", 1'b1, wb_ack);
        rdat = wb_rdat;
        @(negedge clk);
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input bus_adr_t adr, input bus_data_t wdat, input bus_sel_t sel);
        bus_data_t unused;
        bus_access(adr, 1'b1, wdat, sel, unused);
    endtask

    task automatic bus_read(input bus_adr_t adr, output bus_data_t rdat);
        bus_access(adr, 1'b0, '0, '1, rdat);
    endtask

    task automatic read_check(input string name, input bus_adr_t adr, input bus_data_t exp);
        bus_data_t rdat;
        bus_read(adr, rdat);
        check_data(name, exp, rdat);
    endtask

    // Poll until the masked bits match
    task automatic wait_for_bits(input bus_adr_t adr, input bus_data_t mask,
                                 input bus_data_t value);
        bus_data_t rdat;
        bus_read(adr, rdat);
        while ((rdat & mask) != value) begin
            bus_read(adr, rdat);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state();
        check_coil("reset coil", '0, coil);
        check_bit("reset led", 1'b0, led);
        check_bit("reset irq", 1'b0, irq);
        read_check("reset motor ctl", reg_adr(REGION_MOTOR, MOTOR_CTL), '0);
        read_check("reset position", reg_adr(REGION_MOTOR, MOTOR_POSITION), '0);
        read_check("reset phase", reg_adr(REGION_MOTOR, MOTOR_PHASE), '0);
        read_check("reset flags", reg_adr(REGION_SYS, SYS_FLAGS), '0);
    endtask

    task automatic test_led_register();
        bus_write(reg_adr(REGION_SYS, SYS_LED), 32'h1, 4'b0001);
        check_bit("led set", 1'b1, led);
        read_check("led readback", reg_adr(REGION_SYS, SYS_LED), 32'h1);
        // Byte lane 0 disabled, so the bit must hold
        bus_write(reg_adr(REGION_SYS, SYS_LED), 32'h0, 4'b1110);
        check_bit("led masked write", 1'b1, led);
        read_check("led masked readback", reg_adr(REGION_SYS, SYS_LED), 32'h1);
    endtask

    task automatic test_motor_up();
        bus_data_t step;
        rng  = xorshift32(rng);
        step = 1 + (rng % 8);
        bus_write(reg_adr(REGION_MOTOR, MOTOR_STEP), step, '1);
        bus_write(reg_adr(REGION_MOTOR, MOTOR_TARGET), 32'd6, '1);
        bus_write(reg_adr(REGION_MOTOR, MOTOR_CTL), 32'h3, 4'b0001);
        wait_for_bits(reg_adr(REGION_MOTOR, MOTOR_POSITION), '1, 32'd6);
        // Started at phase 0, so phase tracks position modulo 4
        read_check("move up phase", reg_adr(REGION_MOTOR, MOTOR_PHASE), 32'd2);
        check_coil("move up coil", coil_pattern(phase_t'(2)), coil);
        read_check("move up flags", reg_adr(REGION_SYS, SYS_FLAGS), 32'h1 << FLAG_MOTOR);
        check_bit("move up irq", 1'b1, irq);
    endtask

    task automatic test_motor_down();
        bus_write(reg_adr(REGION_SYS, SYS_FLAGS), 32'h1 << FLAG_MOTOR, 4'b0001);
        read_check("flag clear", reg_adr(REGION_SYS, SYS_FLAGS), '0);
        check_bit("irq clear", 1'b0, irq);
        bus_write(reg_adr(REGION_MOTOR, MOTOR_TARGET), 32'd1, '1);
        wait_for_bits(reg_adr(REGION_MOTOR, MOTOR_POSITION), '1, 32'd1);
        read_check("move down phase", reg_adr(REGION_MOTOR, MOTOR_PHASE), 32'd1);
        check_coil("move down coil", coil_pattern(phase_t'(1)), coil);
        read_check("move down flags", reg_adr(REGION_SYS, SYS_FLAGS), 32'h1 << FLAG_MOTOR);
        bus_write(reg_adr(REGION_MOTOR, MOTOR_CTL), 32'h0, 4'b0001);
        check_coil("disabled coil", '0, coil);
        bus_write(reg_adr(REGION_SYS, SYS_FLAGS), 32'h1 << FLAG_MOTOR, 4'b0001);
    endtask

    task automatic test_interval_timer();
        bus_data_t compare;
        bus_data_t count;
        bus_data_t timer_bit;
        rng       = xorshift32(rng);
        compare   = 10 + (rng % 31);
        timer_bit = 32'h1 << FLAG_TIMER;
        bus_write(reg_adr(REGION_TIMER, TIMER_COMPARE), compare, '1);
        bus_write(reg_adr(REGION_TIMER, TIMER_CTL), 32'h1, 4'b0001);
        wait_for_bits(reg_adr(REGION_SYS, SYS_FLAGS), timer_bit, timer_bit);
        bus_read(reg_adr(REGION_TIMER, TIMER_COUNT), count);
        check_bit("timer irq", 1'b1, irq);
        check_count++;
        if (count > compare) begin
            error_count++;
            $display("Error: timer count: expected at most 0x%08h, actual 0x%08h",
                     compare, count);
        end
        bus_write(reg_adr(REGION_SYS, SYS_FLAGS), timer_bit, 4'b0001);
        read_check("timer flag clear", reg_adr(REGION_SYS, SYS_FLAGS), '0);
        // Next period must set it again
        wait_for_bits(reg_adr(REGION_SYS, SYS_FLAGS), timer_bit, timer_bit);
        bus_write(reg_adr(REGION_TIMER, TIMER_CTL), 32'h0, 4'b0001);
    endtask

    task automatic test_unmapped_region();
        read_check("unmapped read", reg_adr(region_e'(8'h00), 16'h0001), '0);
        bus_write(reg_adr(region_e'(8'h00), 16'h0000), 32'h0, '1);
        bus_write(reg_adr(region_e'(8'h00), 16'h0001), 32'h0000_0bad, '1);
        bus_write(reg_adr(region_e'(8'h00), 16'h0003), 32'h0000_dead, '1);
        check_bit("unmapped led", 1'b1, led);
        read_check("unmapped position", reg_adr(REGION_MOTOR, MOTOR_POSITION), 32'd1);
        read_check("unmapped target", reg_adr(REGION_MOTOR, MOTOR_TARGET), 32'd1);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        rng         = 32'h0fd0_126e;
        reset       = 1'b1;
        wb_adr      = '0;
        wb_dat      = '0;
        wb_we       = 1'b0;
        wb_sel      = '0;
        wb_stb      = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_led_register();
        test_motor_up();
        test_motor_down();
        test_interval_timer();
        test_unmapped_region();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/bus_pkg.sv
src/periph_pkg.sv
src/bus_decoder.sv
src/stepper_motor_ctrl.sv
src/interval_timer.sv
src/sys_regs.sv
src/motor_periph_top.sv
bench/tb_motor_periph.sv
